// ==== apple1_bus.f ====
design/apple1_pkg.sv
design/bus_if.sv
design/bus_arbiter.sv
design/mem_bank.sv
design/read_mux.sv
design/apple1_bus.sv
verif/apple1_bus_tb.sv

// ==== design/apple1_bus.sv ====
/*
	apple-1 memory bus, top level
	download and cpu ports merged by the arbiter
	one memory bank per mapped region, built from the region map
	read mux returning the selected byte with a valid strobe
*/
module apple1_bus (
	input  logic              sys_clock,
	input  logic              rst_n,
	input  logic              cpu_clken,
	input  apple1_pkg::addr_t cpu_addr,
	input  apple1_pkg::data_t cpu_wdata,
	input  logic              cpu_we,
	input  logic              dl_active,
	input  logic              dl_wr,
	input  apple1_pkg::addr_t dl_addr,
	input  apple1_pkg::data_t dl_data,
	output apple1_pkg::data_t rd_data,  // valid two edges after the cpu read
	output logic              rd_valid,
	output logic              led       // active low download light
);
	import apple1_pkg::*;

	logic [NUM_BANKS-1:0]  bank_hit;   // per bank read hit
	data_t [NUM_BANKS-1:0] bank_rdata; // per bank read byte

	bus_if bus_i ();

	bus_arbiter arbiter_i (
		.sys_clock (sys_clock),
		.rst_n     (rst_n),
		.cpu_clken (cpu_clken),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_we    (cpu_we),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.led       (led),
		.bus       (bus_i)
	);

	// one bank per entry of the region map
	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
		mem_bank #(
			.BASE         (BANK_BASE[i]),
			.SIZE_LOG2    (BANK_SIZE_LOG2[i]),
			.CPU_WRITABLE (BANK_CPU_WRITABLE[i])
		) bank_i (
			.sys_clock (sys_clock),
			.rst_n     (rst_n),
			.bus       (bus_i),
			.hit       (bank_hit[i]),
			.rdata     (bank_rdata[i])
		);
	end

	read_mux read_mux_i (
		.sys_clock  (sys_clock),
		.rst_n      (rst_n),
		.bus        (bus_i),
		.bank_hit   (bank_hit),
		.bank_rdata (bank_rdata),
		.rd_data    (rd_data),
		.rd_valid   (rd_valid)
	);

endmodule

// ==== design/apple1_pkg.sv ====
/*
	shared definitions of the apple-1 memory bus
	address and data byte types
	number of mapped regions and the region map tables
	base address, size as power of two, cpu write permission per bank
	value returned by a read of unmapped space
*/
package apple1_pkg;

	// cpu address space is 64 KiB, the data bus one byte
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	typedef logic [ADDR_W-1:0] addr_t; // cpu or download address
	typedef logic [DATA_W-1:0] data_t; // one bus byte

	// mapped regions, index 0 main ram, 1 basic ram, 2 monitor rom
	localparam int NUM_BANKS = 3;

	// region start addresses
	// each base is aligned to its own region size
	localparam addr_t BANK_BASE [NUM_BANKS] = '{
		16'h0000, // main ram
		16'hE000, // basic ram
		16'hFF00  // wozmon rom
	};

	// region sizes as log2 of the byte count
	localparam int BANK_SIZE_LOG2 [NUM_BANKS] = '{
		14, // 16 KiB, 0x0000 to 0x3FFF
		12, // 4 KiB, 0xE000 to 0xEFFF
		8   // 256 bytes, 0xFF00 to 0xFFFF
	};

	// cpu write permission per region
	// the download port may write every region
	localparam bit BANK_CPU_WRITABLE [NUM_BANKS] = '{
		1'b1, // main ram
		1'b1, // basic ram, loaded by download but cpu may patch it
		1'b0  // monitor rom is read only for the cpu
	};

	// everything outside the table reads back as this byte
	// covers the old sdram window, aci, vdp and the gaps between
	localparam data_t UNMAPPED_DATA = 8'h00;

endpackage

// ==== design/bus_arbiter.sv ====
/*
	bus arbiter
	merges the download port and the cpu port into one access
	download write wins its cycle, the cpu access of that cycle is lost
	access register towards the banks
	active low activity led while a download write is going on
*/
module bus_arbiter (
	input  logic               sys_clock,
	input  logic               rst_n,
	input  logic               cpu_clken, // one cpu access per pulse
	input  apple1_pkg::addr_t  cpu_addr,
	input  apple1_pkg::data_t  cpu_wdata,
	input  logic               cpu_we,
	input  logic               dl_active, // downloader busy
	input  logic               dl_wr,
	input  apple1_pkg::addr_t  dl_addr,
	input  apple1_pkg::data_t  dl_data,
	output logic               led,       // low = download write in progress
	bus_if.arbiter             bus
);
	import apple1_pkg::*;

	logic  dl_take;   // download write offered this cycle
	logic  next_req;
	logic  next_we;
	addr_t next_addr;
	data_t next_wdata;

	assign dl_take = dl_active & dl_wr;

	// download has priority, no back-pressure on either side
	always_comb begin
		next_req   = dl_take | cpu_clken;
		next_we    = dl_take ? 1'b1 : cpu_we; // downloads are writes only
		next_addr  = dl_take ? dl_addr : cpu_addr;
		next_wdata = dl_take ? dl_data : cpu_wdata;
	end

	// control fields and led
	always_ff @(posedge sys_clock or negedge rst_n) begin
		if (!rst_n) begin
			bus.req     <= 1'b0;
			bus.we      <= 1'b0;
			bus.from_dl <= 1'b0;
			led         <= 1'b1; // led off
		end else begin
			bus.req     <= next_req;
			bus.we      <= next_we & next_req;
			bus.from_dl <= dl_take;
			led         <= ~dl_take;
		end
	end

	// address and write byte, only loaded when an access goes out
	always_ff @(posedge sys_clock) begin
		if (next_req) begin
			bus.addr  <= next_addr;
			bus.wdata <= next_wdata;
		end
	end

endmodule

// ==== design/bus_if.sv ====
/*
	one registered bus access, arbiter to banks and read mux
	modports for the driver, the memory banks and the read monitor
*/
interface bus_if;
	import apple1_pkg::*;

	logic  req;     // access present this cycle, single cycle pulse
	logic  we;      // write when set, read otherwise
	logic  from_dl; // access comes from the download port
	addr_t addr;
	data_t wdata;

	// arbiter owns every field
	modport arbiter (output req, we, from_dl, addr, wdata);

	// banks must take the access in the cycle req is high
	modport bank (input req, we, from_dl, addr, wdata);

	// read mux only needs to know a cpu read went out
	modport monitor (input req, we, from_dl);

endinterface

// ==== design/mem_bank.sv ====
/*
	one memory region of the bus
	address match against base and size
	write protection for cpu writes, download always allowed
	registered read byte with a one cycle hit flag
*/
module mem_bank #(
	parameter apple1_pkg::addr_t BASE         = 16'h0000,
	parameter int                SIZE_LOG2    = 8,
	parameter bit                CPU_WRITABLE = 1'b1
) (
	input  logic              sys_clock,
	input  logic              rst_n,
	bus_if.bank               bus,
	output logic              hit,   // rdata holds a fresh read byte
	output apple1_pkg::data_t rdata
);
	import apple1_pkg::*;

	localparam int unsigned DEPTH = 1 << SIZE_LOG2;

	// one extra bit so the top region limit does not wrap to zero
	typedef logic [ADDR_W:0] wide_addr_t;
	localparam wide_addr_t LIMIT = {1'b0, BASE} + wide_addr_t'(DEPTH);

	data_t                mem [DEPTH]; // region storage
	logic                 sel;         // address falls into this region
	logic [SIZE_LOG2-1:0] offset;
	logic                 wr_en;
	logic                 rd_en;

	assign sel    = (bus.addr >= BASE) && ({1'b0, bus.addr} < LIMIT);
	assign offset = SIZE_LOG2'(bus.addr - BASE); // byte index within the region

	// a cpu write into a protected region is dropped silently
	assign wr_en = bus.req & sel & bus.we & (bus.from_dl | CPU_WRITABLE);
	assign rd_en = bus.req & sel & ~bus.we;

	// storage and read byte
	always_ff @(posedge sys_clock) begin
		if (wr_en) begin
			mem[offset] <= bus.wdata;
		end
		if (rd_en) begin
			rdata <= mem[offset];
		end
	end

	// hit lines up with rdata, high for one cycle per read
	always_ff @(posedge sys_clock or negedge rst_n) begin
		if (!rst_n) begin
			hit <= 1'b0;
		end else begin
			hit <= rd_en;
		end
	end

endmodule

// ==== design/read_mux.sv ====
/*
	read return path
	read valid register, aligned with the bank read stage
	selection of the hitting bank's byte, unmapped reads return zero
*/
module read_mux (
	input  logic                                              sys_clock,
	input  logic                                              rst_n,
	bus_if.monitor                                            bus,
	input  logic [apple1_pkg::NUM_BANKS-1:0]                  bank_hit,
	input  apple1_pkg::data_t [apple1_pkg::NUM_BANKS-1:0]     bank_rdata,
	output apple1_pkg::data_t                                 rd_data,
	output logic                                              rd_valid
);
	import apple1_pkg::*;

	logic cpu_rd; // cpu read on the bus this cycle

	// download accesses are writes, the extra term keeps them out anyway
	assign cpu_rd = bus.req & ~bus.we & ~bus.from_dl;

	// valid for every cpu read, mapped or not
	always_ff @(posedge sys_clock or negedge rst_n) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= cpu_rd;
		end
	end

	// regions never overlap, so at most one hit flag is set
	always_comb begin
		rd_data = UNMAPPED_DATA; // default for unmapped space
		for (int i = 0; i < NUM_BANKS; i++) begin
			if (bank_hit[i]) begin
				rd_data = bank_rdata[i];
			end
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the apple1_bus testbench with verilator
# pass or fail is taken from the simulation log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --top-module apple1_bus_tb -f apple1_bus.f \
	-o apple1_bus_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/apple1_bus_sim > sim.log 2>&1 \
	|| echo "simulator exited with an error status"

grep -q "TESTBENCH PASSED" sim.log \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed, see sim.log"; exit 1; }

// ==== verif/apple1_bus_tb.sv ====
/*
	testbench for the apple-1 memory bus
	clock, reset, dut and a 64 KiB reference memory model
	one compare task, directed test tasks for ram, download, rom protection,
	unmapped space, download priority, idle cycles and back-to-back reads
	watchdog sized from the length of the tests
*/
module apple1_bus_tb;
	import apple1_pkg::*;

	localparam int CLK_PERIOD    = 20;
	localparam int RESET_CYCLES  = 10;
	localparam int IDLE_CYCLES   = 8;
	localparam int N_RAM         = 8;   // cpu writes per ram test
	localparam int ROM_SIZE      = 256;
	localparam int N_BASIC_DL    = 64;  // downloaded basic bytes
	localparam int BURST_LEN     = 16;
	localparam int ACCESS_CYCLES = 5;   // upper bound of one checked access
	localparam int TEST_CYCLES   = RESET_CYCLES + IDLE_CYCLES
		+ ACCESS_CYCLES * (2 * N_RAM + ROM_SIZE + 11 + 5)
		+ ROM_SIZE + N_BASIC_DL + 3 * IDLE_CYCLES + BURST_LEN + 4;

	logic  sys_clock, rst_n, cpu_clken, cpu_we, dl_active, dl_wr;
	addr_t cpu_addr, dl_addr;
	data_t cpu_wdata, dl_data, rd_data;
	logic  rd_valid, led;

	data_t ref_mem [0:65535]; // expected memory contents
	addr_t known_addrs [$];   // ram addresses holding a known byte
	int    seed = 32'h152b_96f0;

	apple1_bus dut_i (
		.sys_clock (sys_clock), .rst_n (rst_n), .cpu_clken (cpu_clken),
		.cpu_addr (cpu_addr), .cpu_wdata (cpu_wdata), .cpu_we (cpu_we),
		.dl_active (dl_active), .dl_wr (dl_wr), .dl_addr (dl_addr), .dl_data (dl_data),
		.rd_data (rd_data), .rd_valid (rd_valid), .led (led)
	);

	always #(CLK_PERIOD / 2) sys_clock = ~sys_clock;

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check_eq(input int actual, input int expected, input string what);
		if (actual != expected) begin
			stop_with_error($sformatf("Fail at time %0t: %s, got 0x%0h, expected 0x%0h",
				$time, what, actual, expected));
		end
	endtask

	// bank index of an address from the region map, -1 when unmapped
	function automatic int region_of(input addr_t a);
		int r;
		r = -1;
		for (int b = 0; b < NUM_BANKS; b++) begin
			if (int'(a) >= int'(BANK_BASE[b]) &&
				int'(a) < int'(BANK_BASE[b]) + (1 << BANK_SIZE_LOG2[b])) begin
				r = b;
			end
		end
		return r;
	endfunction

	// rom only takes download writes, unmapped space takes nothing
	function automatic void model_write(input addr_t a, input data_t d, input bit from_dl);
		int b;
		b = region_of(a);
		if (b >= 0 && (from_dl || BANK_CPU_WRITABLE[b])) begin
			ref_mem[a] = d;
			if (b != 2) known_addrs.push_back(a); // rom stays out of the burst pool
		end
	endfunction

	task automatic cpu_write(input addr_t a, input data_t d);
		@(posedge sys_clock);
		cpu_clken <= 1'b1;
		cpu_we    <= 1'b1;
		cpu_addr  <= a;
		cpu_wdata <= d;
		model_write(a, d, 1'b0);
		@(posedge sys_clock);
		cpu_clken <= 1'b0;
		repeat (2) begin
			@(negedge sys_clock);
			check_eq(int'(rd_valid), 0, "rd_valid after a cpu write"); // writes return nothing
		end
	endtask

	task automatic cpu_read(input addr_t a);
		int lat;
		@(posedge sys_clock);
		cpu_clken <= 1'b1;
		cpu_we    <= 1'b0;
		cpu_addr  <= a;
		@(posedge sys_clock);
		cpu_clken <= 1'b0;
		lat = 0;
		do begin
			@(negedge sys_clock);
			lat++;
		end while (!rd_valid && lat < 2);
		if (!rd_valid) begin
			stop_with_error($sformatf("cpu read at 0x%04h got no rd_valid within 2 cycles", a));
		end
		check_eq(lat, 2, $sformatf("rd_valid latency for 0x%04h", a));
		check_eq(int'(rd_data), int'(ref_mem[a]), $sformatf("read data at 0x%04h", a));
		@(negedge sys_clock);
		check_eq(int'(rd_valid), 0, "rd_valid longer than one cycle"); // single pulse
	endtask

	// one download write per cycle, led checked from the second write on
	task automatic download(input addr_t base, input int count);
		data_t d;
		for (int i = 0; i < count; i++) begin
			@(posedge sys_clock);
			d = data_t'($random(seed));
			dl_active <= 1'b1;
			dl_wr     <= 1'b1;
			dl_addr   <= addr_t'(int'(base) + i);
			dl_data   <= d;
			model_write(addr_t'(int'(base) + i), d, 1'b1);
			@(negedge sys_clock);
			if (i > 0) check_eq(int'(led), 0, "led during download");
		end
		@(posedge sys_clock);
		dl_wr     <= 1'b0;
		dl_active <= 1'b0;
		@(negedge sys_clock);
		check_eq(int'(led), 0, "led on last download write");
		@(negedge sys_clock);
		check_eq(int'(led), 1, "led after download");
	endtask

	task automatic test_reset_idle();
		repeat (IDLE_CYCLES) begin
			@(negedge sys_clock);
			check_eq(int'(rd_valid), 0, "rd_valid after reset");
			check_eq(int'(led), 1, "led after reset"); // active low, off
		end
	endtask

	task automatic test_ram();
		addr_t wr_q [$];
		addr_t a;
		for (int i = 0; i < N_RAM; i++) begin
			if (i % 2 == 0) a = addr_t'($unsigned($random(seed)) % 16384); // main ram
			else a = addr_t'(16'hE000 + $unsigned($random(seed)) % 4096); // basic ram
			wr_q.push_back(a);
			cpu_write(a, data_t'($random(seed)));
		end
		foreach (wr_q[i]) cpu_read(wr_q[i]);
	endtask

	task automatic test_download();
		download(16'hFF00, ROM_SIZE);
		download(16'hE400, N_BASIC_DL);
		for (int i = 0; i < ROM_SIZE; i++) cpu_read(addr_t'(16'hFF00 + i));
	endtask

	task automatic test_protect_unmapped();
		addr_t rom_q [$] = '{16'hFF00, 16'hFF7F, 16'hFFFC, 16'hFFFF};
		foreach (rom_q[i]) cpu_write(rom_q[i], ~ref_mem[rom_q[i]]); // model drops these
		foreach (rom_q[i]) cpu_read(rom_q[i]);
		cpu_read(16'h8000); // old sdram window
		cpu_read(16'hC000);
		cpu_read(16'hF000);
	endtask

	task automatic test_priority_idle();
		cpu_write(16'h0100, 8'h3C);
		@(posedge sys_clock);
		cpu_clken <= 1'b1; // both ports offer in the same cycle
		cpu_we    <= 1'b1;
		cpu_addr  <= 16'h0100;
		cpu_wdata <= 8'hC3;
		dl_active <= 1'b1;
		dl_wr     <= 1'b1;
		dl_addr   <= 16'h0200;
		dl_data   <= 8'h96;
		model_write(16'h0200, 8'h96, 1'b1); // only the download lands
		@(posedge sys_clock);
		cpu_clken <= 1'b0;
		dl_wr     <= 1'b0;
		dl_active <= 1'b0;
		cpu_read(16'h0100);
		cpu_read(16'h0200);
		@(posedge sys_clock);
		cpu_we    <= 1'b1; // write set up but never enabled
		cpu_addr  <= 16'h0100;
		cpu_wdata <= 8'h55;
		repeat (IDLE_CYCLES) begin
			@(negedge sys_clock);
			check_eq(int'(rd_valid), 0, "rd_valid on idle cycles");
		end
		@(posedge sys_clock);
		cpu_we   <= 1'b0; // read set up but never enabled
		cpu_addr <= 16'h0200;
		repeat (IDLE_CYCLES) begin
			@(negedge sys_clock);
			check_eq(int'(rd_valid), 0, "rd_valid on idle read cycles");
		end
		cpu_read(16'h0100);
	endtask

	task automatic test_burst();
		data_t       expect_q [$];
		time         issue_q [$]; // drive time of each outstanding read
		int          got;
		int unsigned r;
		addr_t       a;
		got = 0;
		fork
			begin
				for (int i = 0; i < BURST_LEN; i++) begin
					r = $random(seed);
					a = known_addrs[r % known_addrs.size()];
					@(posedge sys_clock);
					cpu_clken <= 1'b1;
					cpu_we    <= 1'b0;
					cpu_addr  <= a;
					expect_q.push_back(ref_mem[a]);
					issue_q.push_back($time);
				end
				@(posedge sys_clock);
				cpu_clken <= 1'b0;
			end
			begin
				while (got < BURST_LEN) begin
					@(negedge sys_clock);
					if (rd_valid) begin
						if (expect_q.size() == 0) stop_with_error("rd_valid with no read outstanding");
						// one read per cycle at two cycles each keeps two in flight
						check_eq(int'(($time - issue_q.pop_front()) / CLK_PERIOD), 2,
							"burst read latency");
						check_eq(int'(rd_data), int'(expect_q.pop_front()), "burst read data");
						got++;
					end
				end
			end
		join
		@(negedge sys_clock);
		check_eq(int'(rd_valid), 0, "rd_valid after burst");
	endtask

	initial begin
		#(TEST_CYCLES * 2 * CLK_PERIOD);
		stop_with_error("simulation timed out before all tests finished");
	end

	initial begin
		sys_clock = 1'b0;
		rst_n     = 1'b0;
		cpu_clken = 1'b0;
		cpu_we    = 1'b0;
		cpu_addr  = '0;
		cpu_wdata = '0;
		dl_active = 1'b0;
		dl_wr     = 1'b0;
		dl_addr   = '0;
		dl_data   = '0;
		for (int i = 0; i < 65536; i++) ref_mem[i] = '0; // unmapped reads as zero
		repeat (RESET_CYCLES) @(posedge sys_clock);
		rst_n <= 1'b1;
		test_reset_idle();
		test_ram();
		test_download();
		test_protect_unmapped();
		test_priority_idle();
		test_burst();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule
